//--- rtl/fx_pkg.sv
// Fixed-point format defaults and combiner operation enum for the dot-product unit

package fx_pkg;

    // Default sample and result width, one 16-bit word
    localparam int FX_WIDTH = 16;

    // Fraction bits, Q8.8 by default
    localparam int FX_QFRAC = 8;

    // Register stages inside each lane multiplier
    localparam int FX_MUL_LATENCY = 3;

    // Combiner operation, held static while samples are in flight
    typedef enum logic {
        COMB_ADD = 1'b0,    // lane0 + lane1
        COMB_SUB = 1'b1     // lane0 - lane1
    } fx_comb_op_e;

endpackage

//--- rtl/fx_operand_if.sv
// Operand pair interface for one multiplier lane with valid/ready and source/sink modports
`timescale 1ns/1ps

interface fx_operand_if import fx_pkg::*; #(
    parameter int WIDTH = FX_WIDTH
) ();

    logic                    valid;  // a and b are presented
    logic                    ready;  // lane can take the pair this edge
    logic signed [WIDTH-1:0] a;
    logic signed [WIDTH-1:0] b;

    // Producer side, holds valid and data until the pair is taken
    modport source (
        output valid, a, b,
        input  ready
    );

    // Multiplier side
    modport sink (
        input  valid, a, b,
        output ready
    );

endinterface

//--- rtl/fx_mul.sv
// Pipelined signed fixed-point multiplier with round-half-up and whole-pipe stall
`timescale 1ns/1ps

module fx_mul import fx_pkg::*; #(
    parameter int WIDTH   = FX_WIDTH,
    parameter int QFRAC   = FX_QFRAC,
    parameter int LATENCY = FX_MUL_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst_n,
    fx_operand_if.sink              op,
    output logic                    valid,
    input  logic                    ready,
    output logic signed [WIDTH-1:0] result
);

    // Half an output LSB in the double-width product format
    localparam logic signed [2*WIDTH-1:0] HALF_LSB =
        {{(2*WIDTH-1){1'b0}}, 1'b1} << (QFRAC - 1);

    logic [LATENCY-1:0]        v_pipe;                 // One valid bit per stage
    logic signed [2*WIDTH-1:0] prod_raw;
    logic signed [2*WIDTH-1:0] prod_q;                 // Stage 0, full product
    logic signed [2*WIDTH-1:0] prod_rnd;
    logic signed [WIDTH-1:0]   d_pipe [1:LATENCY-1];   // Rounded value, stages 1 and up
    logic                      shift_en;
    logic                      head_en;
    logic                      accept;

    initial begin
        assert (LATENCY >= 2)
            else $error("fx_mul: LATENCY must be at least 2");
        assert (QFRAC > 0)
            else $error("fx_mul: QFRAC must be positive");
    end

    // Pipe moves when the tail is empty or being drained
    assign shift_en = ready || !v_pipe[LATENCY-1];

    // Head stage may also fill a bubble while the rest of the pipe holds
    assign head_en  = shift_en || !v_pipe[0];
    assign op.ready = head_en;
    assign accept   = op.valid && head_en;

    assign prod_raw = op.a * op.b;   // Full 2*WIDTH product, no overflow

    // Round half up, then drop the fraction; the integer part wraps on truncation
    assign prod_rnd = (prod_q + HALF_LSB) >>> QFRAC;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v_pipe <= '0;
        end else begin
            if (head_en)
                v_pipe[0] <= accept;
            if (shift_en)
                v_pipe[LATENCY-1:1] <= v_pipe[LATENCY-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (head_en)
            prod_q <= prod_raw;
        if (shift_en) begin
            d_pipe[1] <= prod_rnd[WIDTH-1:0];
            for (int i = LATENCY - 1; i >= 2; i--)
                d_pipe[i] <= d_pipe[i-1];
        end
    end

    assign valid  = v_pipe[LATENCY-1];
    assign result = d_pipe[LATENCY-1];

    // A stalled result must still be there, unchanged, on the next edge
    a_hold_result: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid && !ready |=> valid && $stable(result)
    ) else $error("fx_mul: held result changed under back-pressure");

endmodule

//--- rtl/fx_sum_sat.sv
// Lane combiner with add/subtract, saturation to the sample range and output register
`timescale 1ns/1ps

module fx_sum_sat import fx_pkg::*; #(
    parameter int WIDTH = FX_WIDTH
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fx_comb_op_e             mode,
    input  logic                    lane0_valid,
    input  logic                    lane1_valid,
    input  logic signed [WIDTH-1:0] lane0_result,
    input  logic signed [WIDTH-1:0] lane1_result,
    output logic                    lane_ready,
    output logic                    valid_out,
    input  logic                    ready_in,
    output logic signed [WIDTH-1:0] result,
    output logic                    sat
);

    localparam logic signed [WIDTH-1:0] SAT_MAX = {1'b0, {(WIDTH-1){1'b1}}};
    localparam logic signed [WIDTH-1:0] SAT_MIN = {1'b1, {(WIDTH-1){1'b0}}};

    logic signed [WIDTH:0]   sum_ext;      // One guard bit above the sample width
    logic signed [WIDTH-1:0] result_nxt;
    logic                    sat_nxt;
    logic                    both_valid;
    logic                    load;

    assign both_valid = lane0_valid && lane1_valid;

    // Output register free or draining this edge
    assign lane_ready = !valid_out || ready_in;
    assign load       = lane_ready && both_valid;

    always_comb begin
        if (mode == COMB_SUB)
            sum_ext = lane0_result - lane1_result;
        else
            sum_ext = lane0_result + lane1_result;
    end

    // Guard bit differs from the sign bit only on overflow
    always_comb begin
        if (sum_ext[WIDTH] == sum_ext[WIDTH-1]) begin
            result_nxt = sum_ext[WIDTH-1:0];
            sat_nxt    = 1'b0;
        end else if (sum_ext[WIDTH]) begin
            result_nxt = SAT_MIN;   // Below the negative limit
            sat_nxt    = 1'b1;
        end else begin
            result_nxt = SAT_MAX;   // Above the positive limit
            sat_nxt    = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            valid_out <= 1'b0;
        else if (lane_ready)
            valid_out <= both_valid;
    end

    // Payload moves only with a new set, holds while stalled
    always_ff @(posedge clk) begin
        if (load) begin
            result <= result_nxt;
            sat    <= sat_nxt;
        end
    end

    // Both multipliers see the same valid and ready, so they must stay in step
    a_lane_lockstep: assert property (
        @(posedge clk) disable iff (!rst_n)
        lane0_valid == lane1_valid
    ) else $error("fx_sum_sat: lane valids out of step");

    // Mode is a static level and must not move while a set is in flight here
    a_mode_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (lane0_valid || lane1_valid || valid_out) |-> $stable(mode)
    ) else $error("fx_sum_sat: mode changed with data in the pipe");

endmodule

//--- rtl/fx_dot2_top.sv
// Two-term fixed-point dot-product top level with two multiplier lanes and a combiner
`timescale 1ns/1ps

module fx_dot2_top import fx_pkg::*; #(
    parameter int WIDTH   = FX_WIDTH,
    parameter int QFRAC   = FX_QFRAC,
    parameter int LATENCY = FX_MUL_LATENCY
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fx_comb_op_e             mode,
    input  logic                    valid_in,
    output logic                    ready_out,
    input  logic signed [WIDTH-1:0] a0,
    input  logic signed [WIDTH-1:0] b0,
    input  logic signed [WIDTH-1:0] a1,
    input  logic signed [WIDTH-1:0] b1,
    output logic                    valid_out,
    input  logic                    ready_in,
    output logic signed [WIDTH-1:0] result,
    output logic                    sat
);

    logic                    lane0_valid;
    logic                    lane1_valid;
    logic signed [WIDTH-1:0] lane0_result;
    logic signed [WIDTH-1:0] lane1_result;
    logic                    lane_ready;   // Shared by both lanes

    fx_operand_if #(.WIDTH(WIDTH)) lane0_op ();
    fx_operand_if #(.WIDTH(WIDTH)) lane1_op ();

    // One valid feeds both lanes so they fill and drain together
    assign lane0_op.valid = valid_in;
    assign lane0_op.a     = a0;
    assign lane0_op.b     = b0;
    assign lane1_op.valid = valid_in;
    assign lane1_op.a     = a1;
    assign lane1_op.b     = b1;
    assign ready_out      = lane0_op.ready;   // Lane 1 ready is identical

    fx_mul #(
        .WIDTH   (WIDTH),
        .QFRAC   (QFRAC),
        .LATENCY (LATENCY)
    ) lane0_mul_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (lane0_op.sink),
        .valid  (lane0_valid),
        .ready  (lane_ready),
        .result (lane0_result)
    );

    fx_mul #(
        .WIDTH   (WIDTH),
        .QFRAC   (QFRAC),
        .LATENCY (LATENCY)
    ) lane1_mul_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .op     (lane1_op.sink),
        .valid  (lane1_valid),
        .ready  (lane_ready),
        .result (lane1_result)
    );

    fx_sum_sat #(
        .WIDTH (WIDTH)
    ) comb_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .mode         (mode),
        .lane0_valid  (lane0_valid),
        .lane1_valid  (lane1_valid),
        .lane0_result (lane0_result),
        .lane1_result (lane1_result),
        .lane_ready   (lane_ready),
        .valid_out    (valid_out),
        .ready_in     (ready_in),
        .result       (result),
        .sat          (sat)
    );

endmodule

//--- bench/fx_dot2_tb.sv
// Pattern-driven self-checking testbench for the two-term dot-product unit
`timescale 1ns/1ps

module fx_dot2_tb import fx_pkg::*; ();

    localparam int WIDTH     = FX_WIDTH;
    localparam int LATENCY   = FX_MUL_LATENCY;
    localparam int MAX_PAT   = 64;
    localparam int NUM_TESTS = 5;

    logic                    clk = 1'b0;
    logic                    rst_n;
    fx_comb_op_e             mode;
    logic                    valid_in;
    logic                    ready_out;
    logic                    valid_out;
    logic                    ready_in;
    logic                    sat;
    logic signed [WIDTH-1:0] a0, b0, a1, b1;
    logic signed [WIDTH-1:0] result;

    logic [15:0]      pat [0:8*MAX_PAT-1];   // Eight words per sample set
    int               n_pat;
    int               limit;
    int               cycles;
    int               n_pass;
    int               n_fail;
    int               n_recv;
    int               seed_rv;
    logic             bp_on;                 // Random back-pressure enable
    logic [WIDTH-1:0] exp_res_q [$];
    logic             exp_sat_q [$];
    int               acc_cyc_q [$];         // Cycle of acceptance per set
    int               set_q [$];
    logic             held;
    logic             hold_sat;
    logic [WIDTH-1:0] hold_res;

    fx_dot2_top #(
        .WIDTH   (WIDTH),
        .QFRAC   (FX_QFRAC),
        .LATENCY (LATENCY)
    ) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .mode      (mode),
        .valid_in  (valid_in),
        .ready_out (ready_out),
        .a0        (a0),
        .b0        (b0),
        .a1        (a1),
        .b1        (b1),
        .valid_out (valid_out),
        .ready_in  (ready_in),
        .result    (result),
        .sat       (sat)
    );

    always #4 clk = ~clk;

    // Run limit grows with the number of sets
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, outputs missing: only %0d of %0d results came out",
                     cycles, n_recv, n_pat);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Downstream ready, random only in the back-pressure test
    initial begin
        seed_rv = $urandom(60102);
        forever begin
            @(posedge clk);
            if (bp_on)
                ready_in <= ($urandom % 3) != 0;   // Roughly one stall in three
            else
                ready_in <= 1'b1;
        end
    end

    task automatic check_output;
        logic [WIDTH-1:0] e_res;
        logic             e_sat;
        int               a_cyc;
        int               idx;
        begin
            if (exp_res_q.size() == 0) begin
                $display("Output %h appeared at %0t with no set waiting for it", result, $time);
                n_fail++;
            end else begin
                e_res = exp_res_q.pop_front();
                e_sat = exp_sat_q.pop_front();
                a_cyc = acc_cyc_q.pop_front();
                idx   = set_q.pop_front();
                n_recv++;
                if (result !== e_res || sat !== e_sat) begin
                    $display("ERR t=%0t: set %0d gave %h sat %b, expected %h sat %b",
                             $time, idx, result, sat, e_res, e_sat);
                    n_fail++;
                end else
                    n_pass++;
                if (!bp_on && cycles - a_cyc != LATENCY + 1) begin
                    $display("ERR t=%0t: set %0d took %0d cycles, expected %0d",
                             $time, idx, cycles - a_cyc, LATENCY + 1);
                    n_fail++;
                end
            end
        end
    endtask

    // Output side, values sampled before this edge's updates
    always @(posedge clk) begin
        if (rst_n) begin
            if (held && (result !== hold_res || sat !== hold_sat)) begin
                $display("ERR t=%0t: stalled output moved to %h sat %b from %h sat %b",
                         $time, result, sat, hold_res, hold_sat);
                n_fail++;
            end
            if (valid_out && ready_in)
                check_output();
            held     = valid_out && !ready_in;
            hold_res = result;
            hold_sat = sat;
        end
    end

    task automatic send_set(input int k);
        int base;
        begin
            base = 8 * k;
            valid_in <= 1'b1;
            a0       <= pat[base+2];
            b0       <= pat[base+3];
            a1       <= pat[base+4];
            b1       <= pat[base+5];
            do @(posedge clk); while (!ready_out);
            exp_res_q.push_back(pat[base+6]);
            exp_sat_q.push_back(pat[base+7][0]);
            acc_cyc_q.push_back(cycles);
            set_q.push_back(k);
        end
    endtask

    // Wait until every accepted set has left the output register
    task automatic drain;
        begin
            valid_in <= 1'b0;
            do @(posedge clk); while (exp_res_q.size() != 0 || valid_out);
        end
    endtask

    task automatic report_test(input int t, input int sets, input int errs);
        begin
            case (t)
                1: $write("test 1 reset and latency");
                2: $write("test 2 add with rounding");
                3: $write("test 3 subtract");
                4: $write("test 4 saturation");
                default: $write("test 5 back-pressure");
            endcase
            $display(": %0d sets, %0d errors", sets, errs);
        end
    endtask

    task automatic run_test(input int t);
        int k;
        int sets;
        int fail0;
        begin
            sets  = 0;
            fail0 = n_fail;
            bp_on <= (t == 5);
            for (k = 0; k < n_pat; k++) begin
                if (pat[8*k] == t) begin
                    // Mode only moves with the pipe empty
                    if (pat[8*k+1][0] != (mode == COMB_SUB)) begin
                        drain();
                        mode <= pat[8*k+1][0] ? COMB_SUB : COMB_ADD;
                    end
                    send_set(k);
                    sets++;
                end
            end
            drain();
            bp_on <= 1'b0;
            report_test(t, sets, n_fail - fail0);
        end
    endtask

    initial begin
        rst_n    = 1'b0;
        mode     = COMB_ADD;
        valid_in = 1'b0;
        a0       = '0;
        b0       = '0;
        a1       = '0;
        b1       = '0;
        ready_in = 1'b1;
        bp_on    = 1'b0;
        held     = 1'b0;
        $readmemh("bench/fx_dot2_patterns.txt", pat);
        n_pat = 0;
        while (n_pat < MAX_PAT && !$isunknown(pat[8*n_pat]))
            n_pat++;
        if (n_pat == 0) begin
            $display("No sample sets could be read from the pattern file");
            n_fail++;
        end
        limit = 64 + 20 * n_pat;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (valid_out !== 1'b0 || ready_out !== 1'b1) begin
            $display("ERR t=%0t: after reset valid_out %b ready_out %b, expected 0 and 1",
                     $time, valid_out, ready_out);
            n_fail++;
        end else
            n_pass++;
        for (int t = 1; t <= NUM_TESTS; t++)
            run_test(t);
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- bench/fx_dot2_patterns.txt
// Columns: test mode a0 b0 a1 b1 expected_result expected_sat, all hex, samples in Q8.8
// Mode 0 adds the lane products, mode 1 subtracts lane 1 from lane 0
// Test 1, single set for reset and latency
1 0 0100 0200 0080 0100 0280 0
// Test 2, add with half-LSB rounding
2 0 0001 0080 0001 0001 0001 0
2 0 0180 0180 0040 0040 0250 0
2 0 0003 0080 0005 0080 0005 0
2 0 ff00 0300 0200 0200 0100 0
2 0 0001 0001 0002 0040 0001 0
2 0 0000 1234 0000 7fff 0000 0
2 0 0100 0100 0100 ff00 0000 0
2 0 0a00 0b00 0100 0a00 7800 0
// Test 3, subtract with sign changes, negative rounding and product wrap
3 1 0100 0200 0100 0300 ff00 0
3 1 ffff 0080 fffd 0080 0001 0
3 1 fffb 0080 0003 0080 fffc 0
3 1 0300 0300 0200 0200 0500 0
3 1 fe00 0180 ff80 0200 fe00 0
3 1 ffff 0001 ff00 0001 0001 0
3 1 1000 1000 0100 0100 ff00 0
// Test 4, saturation at both limits in both modes
4 0 4000 0180 4000 0100 7fff 1
4 0 c000 0180 c000 0100 8000 1
4 0 7fff 0100 0000 0000 7fff 0
4 0 7fff 0100 0001 0100 7fff 1
4 1 4000 0100 c000 0180 7fff 1
4 1 c000 0100 4000 0180 8000 1
4 1 8000 0100 0000 0000 8000 0
4 1 8000 0100 0001 0100 8000 1
// Test 5, back-to-back sets under random back-pressure
5 0 0010 0100 0020 0100 0030 0
5 0 0011 0100 0022 0100 0033 0
5 0 0100 0100 ff00 0100 0000 0
5 0 1234 0100 0111 0100 1345 0
5 0 7000 0100 2000 0100 7fff 1
5 0 0001 0080 0001 0080 0002 0
5 0 ffff 0080 ffff 0080 0000 0
5 0 0200 0200 0300 0300 0d00 0
5 0 8000 0100 f000 0100 8000 1
5 0 0abc 0100 0001 0100 0abd 0
5 0 fffd 0080 0003 0080 0001 0
5 0 0180 0180 0180 0180 0480 0
5 1 0300 0300 0200 0200 0500 0
5 1 0010 0100 0020 0100 fff0 0
5 1 c000 0100 4000 0180 8000 1

//--- verilog.f
rtl/fx_pkg.sv
rtl/fx_operand_if.sv
rtl/fx_mul.sv
rtl/fx_sum_sat.sv
rtl/fx_dot2_top.sv
bench/fx_dot2_tb.sv

//--- Bender.yml
package:
  name: fx_dot2

sources:
  - rtl/fx_pkg.sv
  - rtl/fx_operand_if.sv
  - rtl/fx_mul.sv
  - rtl/fx_sum_sat.sv
  - rtl/fx_dot2_top.sv
  - target: test
    files:
      - bench/fx_dot2_tb.sv
